// File: verilog/rxDma_params.svh
`ifndef RXDMA_PARAMS_SVH
`define RXDMA_PARAMS_SVH

// ------------------------------------------------------------
// Receive DMA controller sizing
// ------------------------------------------------------------

// Number of independent receive flows
`define RXDMA_FLOWS 4

// Host buffer address width
`define RXDMA_ADDR_WIDTH 32

// Packet length in words
`define RXDMA_LEN_WIDTH 12

// Packet records buffered per flow
`define RXDMA_FIFO_DEPTH 4

`endif

// File: verilog/rxDmaPkg.sv
`include "rxDma_params.svh"

package rxDmaPkg;

  // ------------------------------------------------------------
  // Shared types of the receive DMA controller
  // ------------------------------------------------------------

  // Flow number
  typedef logic [$clog2(`RXDMA_FLOWS)-1:0] flowIdxT;

  // Packet length in words
  typedef logic [`RXDMA_LEN_WIDTH-1:0] wordLenT;

  // Host buffer address from a descriptor
  typedef logic [`RXDMA_ADDR_WIDTH-1:0] hostAddrT;

  // One completed packet, as queued per flow
  // Only the length is kept, the data path lives elsewhere
  typedef struct packed {
    wordLenT len;
  } pktRecordT;

endpackage

// File: verilog/recordFifo.sv
`timescale 1ns/1ns

module recordFifo #(
  parameter type payloadT = logic [7:0],
  parameter int DEPTH = 4
) (
  input  logic    CLK,
  input  logic    rst,
  input  logic    push,
  input  payloadT pushData,
  input  logic    pop,
  output payloadT popData,
  output logic    empty,
  output logic    full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payloadT          mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             doPush;
  logic             doPop;

  // Step a pointer around the ring
  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Push while full and pop while empty are dropped
  assign doPush = push && !full;
  assign doPop  = pop && !empty;

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  // Head entry is visible without a pop
  assign popData = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= nextPtr(wrPtr);
      if (doPop) rdPtr <= nextPtr(rdPtr);
      // Occupancy only moves when exactly one side acts
      if (doPush && !doPop) count <= count + 1'b1;
      else if (doPop && !doPush) count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge CLK) begin
    if (doPush) mem[wrPtr] <= pushData;
  end

endmodule

// File: verilog/rxFrameInput.sv
`timescale 1ns/1ns
`include "rxDma_params.svh"

module rxFrameInput import rxDmaPkg::*; (
  input  logic                          CLK,
  input  logic                          rst,
  input  logic [`RXDMA_FLOWS-1:0]       wordValid,
  input  logic [`RXDMA_FLOWS-1:0]       wordLast,
  input  logic [`RXDMA_FLOWS-1:0]       pktPop,
  output logic [`RXDMA_FLOWS-1:0]       pktPending,
  output wordLenT [`RXDMA_FLOWS-1:0]    pktLen,
  output logic [`RXDMA_FLOWS-1:0]       overflow
);

  // ------------------------------------------------------------
  // Per-flow word counting and packet records
  // ------------------------------------------------------------
  for (genvar f = 0; f < `RXDMA_FLOWS; f++) begin : gFlow
    wordLenT   wordCnt;
    pktRecordT newRec;
    pktRecordT headRec;
    logic      lastWord;
    logic      fifoFull;
    logic      fifoEmpty;
    logic      ovfFlag;

    // Packet completes on its last accepted word
    assign lastWord = wordValid[f] && wordLast[f];

    // Length counts the last word too
    assign newRec = '{len: wordCnt + 1'b1};

    always_ff @(posedge CLK) begin
      if (rst) begin
        wordCnt <= '0;
      end else if (wordValid[f]) begin
        // Restart for the next packet
        if (wordLast[f]) wordCnt <= '0;
        else wordCnt <= wordCnt + 1'b1;
      end
    end

    // Sticky until reset
    // The packet that hit a full queue is lost
    always_ff @(posedge CLK) begin
      if (rst) begin
        ovfFlag <= 1'b0;
      end else if (lastWord && fifoFull) begin
        ovfFlag <= 1'b1;
      end
    end

    recordFifo #(
      .payloadT (pktRecordT),
      .DEPTH    (`RXDMA_FIFO_DEPTH)
    ) recordFifo_inst (
      .CLK      (CLK),
      .rst      (rst),
      .push     (lastWord && !fifoFull),
      .pushData (newRec),
      .pop      (pktPop[f]),
      .popData  (headRec),
      .empty    (fifoEmpty),
      .full     (fifoFull)
    );

    // Queue state towards the scheduler, one cycle after the last word
    assign pktPending[f] = !fifoEmpty;
    assign pktLen[f]     = headRec.len;
    assign overflow[f]   = ovfFlag;
  end

endmodule

// File: verilog/descScheduler.sv
`timescale 1ns/1ns
`include "rxDma_params.svh"

module descScheduler import rxDmaPkg::*; (
  input  logic                       CLK,
  input  logic                       rst,
  input  logic [`RXDMA_FLOWS-1:0]    run,
  input  logic [`RXDMA_FLOWS-1:0]    suHfull,
  input  logic [`RXDMA_FLOWS-1:0]    descEmpty,
  input  logic [`RXDMA_FLOWS-1:0]    pktPending,
  input  wordLenT [`RXDMA_FLOWS-1:0] pktLen,
  input  logic                       outBusy,
  output logic                       descRead,
  output flowIdxT                    descFlow,
  input  logic                       descValid,
  input  hostAddrT                   descAddr,
  output logic                       issue,
  output flowIdxT                    issueFlow,
  output hostAddrT                   issueAddr,
  output wordLenT                    issueLen,
  output logic [`RXDMA_FLOWS-1:0]    pktPop,
  output logic                       waiting
);

  typedef enum logic [1:0] {
    WAITING,
    READING,
    ISSUING
  } stateT;

  stateT                   state;
  // Flow being served, also the round-robin pointer
  flowIdxT                 curFlow;
  logic [`RXDMA_FLOWS-1:0] eligible;
  logic                    found;
  flowIdxT                 nextFlow;
  logic                    startRead;
  wordLenT                 lenReg;
  hostAddrT                addrReg;

  // ------------------------------------------------------------
  // Eligibility and round-robin pick
  // ------------------------------------------------------------
  assign eligible = run & ~suHfull & ~descEmpty & pktPending;

  // Search starts one past the last served flow
  always_comb begin
    int idx;
    found    = 1'b0;
    nextFlow = curFlow;
    for (int i = 1; i <= `RXDMA_FLOWS; i++) begin
      idx = (int'(curFlow) + i) % `RXDMA_FLOWS;
      if (!found && eligible[idx]) begin
        found    = 1'b1;
        nextFlow = flowIdxT'(idx);
      end
    end
  end

  // No new read while the output side still holds a request
  assign startRead = (state == WAITING) && found && !outBusy;

  // ------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (rst) begin
      state    <= WAITING;
      // First search then begins at flow 0
      curFlow  <= flowIdxT'(`RXDMA_FLOWS - 1);
      descRead <= 1'b0;
    end else begin
      descRead <= 1'b0;
      case (state)
        WAITING: begin
          if (startRead) begin
            state    <= READING;
            curFlow  <= nextFlow;
            descRead <= 1'b1;
          end
        end
        // Descriptor latency varies
        READING: if (descValid) state <= ISSUING;
        // One cycle of issue, then look again
        ISSUING: state <= WAITING;
        default: state <= WAITING;
      endcase
    end
  end

  // Length frozen at read time, address at descriptor return
  always_ff @(posedge CLK) begin
    if (startRead) lenReg <= pktLen[nextFlow];
    if (state == READING && descValid) addrReg <= descAddr;
  end

  // Outputs
  assign descFlow  = curFlow;
  assign issue     = (state == ISSUING);
  assign issueFlow = curFlow;
  assign issueAddr = addrReg;
  assign issueLen  = lenReg;
  assign waiting   = (state == WAITING);

  // Served record leaves its queue together with the issue
  always_comb begin
    for (int f = 0; f < `RXDMA_FLOWS; f++) begin
      pktPop[f] = issue && (curFlow == flowIdxT'(f));
    end
  end

endmodule

// File: verilog/dmaRequestOut.sv
`timescale 1ns/1ns

module dmaRequestOut import rxDmaPkg::*; (
  input  logic     CLK,
  input  logic     rst,
  input  logic     issue,
  input  flowIdxT  issueFlow,
  input  hostAddrT issueAddr,
  input  wordLenT  issueLen,
  input  logic     dmaAck,
  output logic     dmaReq,
  output flowIdxT  dmaFlow,
  output hostAddrT dmaAddr,
  output wordLenT  dmaLen,
  output logic     suValid,
  output flowIdxT  suFlow,
  output wordLenT  suLen,
  output logic     outBusy
);

  // ------------------------------------------------------------
  // Request hold and status update
  // ------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (rst) begin
      dmaReq  <= 1'b0;
      suValid <= 1'b0;
    end else begin
      suValid <= 1'b0;
      if (issue) begin
        dmaReq <= 1'b1;
      end else if (dmaReq && dmaAck) begin
        // Request drops as the status update goes out
        dmaReq  <= 1'b0;
        suValid <= 1'b1;
      end
    end
  end

  // Request fields, then status fields on the acknowledge
  always_ff @(posedge CLK) begin
    if (issue) begin
      dmaFlow <= issueFlow;
      dmaAddr <= issueAddr;
      dmaLen  <= issueLen;
    end
    if (dmaReq && dmaAck) begin
      suFlow <= dmaFlow;
      suLen  <= dmaLen;
    end
  end

  // Busy from the issue cycle up to and including the ack cycle
  assign outBusy = issue || dmaReq;

endmodule

// File: verilog/rxDmaCtrl.sv
`timescale 1ns/1ns
`include "rxDma_params.svh"

module rxDmaCtrl import rxDmaPkg::*; (
  input  logic                    CLK,
  input  logic                    rst,
  input  logic [`RXDMA_FLOWS-1:0] wordValid,
  input  logic [`RXDMA_FLOWS-1:0] wordLast,
  input  logic [`RXDMA_FLOWS-1:0] run,
  input  logic [`RXDMA_FLOWS-1:0] suHfull,
  input  logic [`RXDMA_FLOWS-1:0] descEmpty,
  output logic                    descRead,
  output flowIdxT                 descFlow,
  input  logic                    descValid,
  input  hostAddrT                descAddr,
  output logic                    dmaReq,
  output flowIdxT                 dmaFlow,
  output hostAddrT                dmaAddr,
  output wordLenT                 dmaLen,
  input  logic                    dmaAck,
  output logic                    suValid,
  output flowIdxT                 suFlow,
  output wordLenT                 suLen,
  output logic [`RXDMA_FLOWS-1:0] overflow,
  output logic                    idle
);

  logic [`RXDMA_FLOWS-1:0] pktPending;
  wordLenT [`RXDMA_FLOWS-1:0] pktLen;
  logic [`RXDMA_FLOWS-1:0] pktPop;
  logic                    outBusy;
  logic                    issue;
  flowIdxT                 issueFlow;
  hostAddrT                issueAddr;
  wordLenT                 issueLen;
  logic                    waiting;

  // ------------------------------------------------------------
  // Input side
  // ------------------------------------------------------------
  rxFrameInput rxFrameInput_inst (
    .CLK        (CLK),
    .rst        (rst),
    .wordValid  (wordValid),
    .wordLast   (wordLast),
    .pktPop     (pktPop),
    .pktPending (pktPending),
    .pktLen     (pktLen),
    .overflow   (overflow)
  );

  // ------------------------------------------------------------
  // Scheduler
  // ------------------------------------------------------------
  descScheduler descScheduler_inst (
    .CLK        (CLK),
    .rst        (rst),
    .run        (run),
    .suHfull    (suHfull),
    .descEmpty  (descEmpty),
    .pktPending (pktPending),
    .pktLen     (pktLen),
    .outBusy    (outBusy),
    .descRead   (descRead),
    .descFlow   (descFlow),
    .descValid  (descValid),
    .descAddr   (descAddr),
    .issue      (issue),
    .issueFlow  (issueFlow),
    .issueAddr  (issueAddr),
    .issueLen   (issueLen),
    .pktPop     (pktPop),
    .waiting    (waiting)
  );

  // ------------------------------------------------------------
  // Output side
  // ------------------------------------------------------------
  dmaRequestOut dmaRequestOut_inst (
    .CLK       (CLK),
    .rst       (rst),
    .issue     (issue),
    .issueFlow (issueFlow),
    .issueAddr (issueAddr),
    .issueLen  (issueLen),
    .dmaAck    (dmaAck),
    .dmaReq    (dmaReq),
    .dmaFlow   (dmaFlow),
    .dmaAddr   (dmaAddr),
    .dmaLen    (dmaLen),
    .suValid   (suValid),
    .suFlow    (suFlow),
    .suLen     (suLen),
    .outBusy   (outBusy)
  );

  // Idle when nothing is in flight and nothing could start
  assign idle = waiting && !(|(run & ~suHfull & ~descEmpty & pktPending)) && !outBusy;

endmodule

// File: verification/rxDmaTests.svh
// ------------------------------------------------------------
// Stimulus and response helpers
// ------------------------------------------------------------

// One word per cycle with the last word flagged
task automatic sendPacket(input int flow, input int len);
  for (int w = 0; w < len; w++) begin
    wordValid[flow] = 1'b1;
    wordLast[flow]  = (w == len - 1);
    step();
  end
  wordValid[flow] = 1'b0;
  wordLast[flow]  = 1'b0;
endtask

task automatic waitDescRead();
  for (int i = 0; i < TIMEOUT; i++) begin
    if (descRead) return;
    step();
  end
  reportTimeout("descriptor read");
endtask

task automatic waitDmaReq();
  for (int i = 0; i < TIMEOUT; i++) begin
    if (dmaReq) return;
    step();
  end
  reportTimeout("DMA request");
endtask

// Nothing may start for a while
task automatic expectQuiet(input int cycles);
  repeat (cycles) begin
    checkEq("descRead while blocked", descRead, 0);
    checkEq("idle while blocked", idle, 1);
    step();
  end
endtask

// Full service of one packet with the ack held back ackDelay cycles
task automatic serveExpect(input int flow, input int len, input int ackDelay);
  waitDescRead();
  checkEq("descFlow", descFlow, flow);
  waitDmaReq();
  checkEq("descValid to dmaReq cycles", cycleCnt - validCycle, 2);
  checkEq("dmaFlow", dmaFlow, flow);
  checkEq("dmaAddr", dmaAddr, lastDescAddr);
  checkEq("dmaLen", dmaLen, len);
  repeat (ackDelay) begin
    step();
    checkEq("dmaReq before ack", dmaReq, 1);
    checkEq("descRead while request open", descRead, 0);
  end
  dmaAck = 1'b1;
  step();
  dmaAck = 1'b0;
  // Status update one cycle after the ack
  checkEq("suValid", suValid, 1);
  checkEq("suFlow", suFlow, flow);
  checkEq("suLen", suLen, len);
  checkEq("dmaReq after ack", dmaReq, 0);
endtask

// ------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------
task automatic resetState();
  $display("Test: reset state");
  checkEq("descRead", descRead, 0);
  checkEq("dmaReq", dmaReq, 0);
  checkEq("suValid", suValid, 0);
  checkEq("overflow", overflow, 0);
  checkEq("idle", idle, 1);
endtask

task automatic singlePacket();
  $display("Test: single packet");
  sendPacket(2, 5);
  serveExpect(2, 5, 0);
  step();
  checkEq("idle after service", idle, 1);
endtask

// Each level blocks one flow in turn until its release
task automatic gatingLevels();
  int len;
  $display("Test: gating levels");
  for (int k = 0; k < 3; k++) begin
    len = 1 + takeBits(4);
    if (k == 0) run[1] = 1'b0;
    else if (k == 1) suHfull[2] = 1'b1;
    else descEmpty[3] = 1'b1;
    sendPacket(k + 1, len);
    expectQuiet(20);
    run       = '1;
    suHfull   = '0;
    descEmpty = '0;
    serveExpect(k + 1, len, 0);
  end
endtask

// Flow 3 was served last before this test
task automatic roundRobinOrder();
  int lens [FLOWS];
  $display("Test: round-robin order");
  run = '0;
  for (int f = 0; f < FLOWS; f++) begin
    lens[f] = 1 + takeBits(4);
    sendPacket(f, lens[f]);
  end
  expectQuiet(5);
  run = '1;
  serveExpect(0, lens[0], 0);
  serveExpect(1, lens[1], 0);
  serveExpect(2, lens[2], 0);
  serveExpect(3, lens[3], 0);
  // Flow 3 queued first yet flow 0 comes next after flow 3
  run = '0;
  lens[3] = 1 + takeBits(4);
  sendPacket(3, lens[3]);
  lens[0] = 1 + takeBits(4);
  sendPacket(0, lens[0]);
  run = '1;
  serveExpect(0, lens[0], 0);
  serveExpect(3, lens[3], 0);
endtask

// Flow 2 waits behind the held request of flow 1
task automatic ackBackPressure();
  int lens [FLOWS];
  $display("Test: back-pressure");
  run = '0;
  for (int f = 1; f < 3; f++) begin
    lens[f] = 1 + takeBits(4);
    sendPacket(f, lens[f]);
  end
  run = '1;
  serveExpect(1, lens[1], 6);
  serveExpect(2, lens[2], 6);
endtask

task automatic fifoOverflow();
  int lens [`RXDMA_FIFO_DEPTH + 1];
  $display("Test: overflow");
  run[0] = 1'b0;
  for (int p = 0; p <= `RXDMA_FIFO_DEPTH; p++) begin
    lens[p] = 1 + takeBits(4);
    sendPacket(0, lens[p]);
    if (p < `RXDMA_FIFO_DEPTH) checkEq("overflow before full", overflow, 0);
  end
  checkEq("overflow after extra packet", overflow, 4'b0001);
  run[0] = 1'b1;
  for (int p = 0; p < `RXDMA_FIFO_DEPTH; p++) serveExpect(0, lens[p], 0);
  // Dropped packet never shows up
  expectQuiet(20);
  checkEq("overflow stays set", overflow, 4'b0001);
endtask

// File: verification/rxDmaTb.sv
`timescale 1ns/1ns
`include "rxDma_params.svh"

module rxDmaTb import rxDmaPkg::*; ();

  localparam int FLOWS = `RXDMA_FLOWS;
  localparam int TIMEOUT = 40;

  logic             CLK;
  logic             rst;
  logic [FLOWS-1:0] wordValid;
  logic [FLOWS-1:0] wordLast;
  logic [FLOWS-1:0] run;
  logic [FLOWS-1:0] suHfull;
  logic [FLOWS-1:0] descEmpty;
  logic             descRead;
  flowIdxT          descFlow;
  logic             descValid;
  hostAddrT         descAddr;
  logic             dmaReq;
  flowIdxT          dmaFlow;
  hostAddrT         dmaAddr;
  wordLenT          dmaLen;
  logic             dmaAck;
  logic             suValid;
  flowIdxT          suFlow;
  wordLenT          suLen;
  logic [FLOWS-1:0] overflow;
  logic             idle;

  // Free-running cycle index and descriptor model bookkeeping
  int          cycleCnt = 0;
  int          validCycle;
  hostAddrT    lastDescAddr;
  int          descSeq [FLOWS];
  logic [31:0] lfsrState = 32'he05d;

  rxDmaCtrl rxDmaCtrl_inst (
    .CLK       (CLK),
    .rst       (rst),
    .wordValid (wordValid),
    .wordLast  (wordLast),
    .run       (run),
    .suHfull   (suHfull),
    .descEmpty (descEmpty),
    .descRead  (descRead),
    .descFlow  (descFlow),
    .descValid (descValid),
    .descAddr  (descAddr),
    .dmaReq    (dmaReq),
    .dmaFlow   (dmaFlow),
    .dmaAddr   (dmaAddr),
    .dmaLen    (dmaLen),
    .dmaAck    (dmaAck),
    .suValid   (suValid),
    .suFlow    (suFlow),
    .suLen     (suLen),
    .overflow  (overflow),
    .idle      (idle)
  );

  // ------------------------------------------------------------
  // Clock, cycle count and shared helpers
  // ------------------------------------------------------------
  always #5 CLK = ~CLK;

  always @(posedge CLK) cycleCnt <= cycleCnt + 1;

  // Next sample and drive point 1 ns past the rising edge
  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic int takeBits(input int count);
    int   value;
    logic lsb;
    value = 0;
    for (int i = 0; i < count; i++) begin
      lsb = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (lsb) lfsrState = lfsrState ^ 32'h8020_0003;
      value = (value << 1) | int'(lfsrState[0]);
    end
    return value;
  endfunction

  task automatic checkEq(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Stopped on the first mismatch");
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("Timeout at %0t ns: %s never arrived", $time, what);
    $display(">>> FAIL");
    $fatal(1, "Stopped on a timeout");
  endtask

  // ------------------------------------------------------------
  // Descriptor source model
  // ------------------------------------------------------------
  // Answers a read after 1 to 4 cycles
  // address is base plus flow in the upper half plus a sequence count
  always begin : descModel
    int flow;
    int delay;
    step();
    if (descRead) begin
      flow  = int'(descFlow);
      delay = 1 + takeBits(2);
      repeat (delay) step();
      descAddr = 32'h8000_0000 + (hostAddrT'(flow) << 16) + hostAddrT'(descSeq[flow]);
      descSeq[flow] = descSeq[flow] + 1;
      lastDescAddr = descAddr;
      validCycle = cycleCnt;
      descValid = 1'b1;
      step();
      descValid = 1'b0;
    end
  end

  `include "rxDmaTests.svh"

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    CLK       = 1'b0;
    rst       = 1'b1;
    wordValid = '0;
    wordLast  = '0;
    run       = '1;
    suHfull   = '0;
    descEmpty = '0;
    descValid = 1'b0;
    descAddr  = '0;
    dmaAck    = 1'b0;
    for (int f = 0; f < FLOWS; f++) descSeq[f] = 0;
    // Reset held for 4 cycles
    repeat (4) step();
    rst = 1'b0;
    resetState();
    singlePacket();
    gatingLevels();
    roundRobinOrder();
    ackBackPressure();
    fifoOverflow();
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: files.f
+incdir+verilog
+incdir+verification
verilog/rxDmaPkg.sv
verilog/recordFifo.sv
verilog/rxFrameInput.sv
verilog/descScheduler.sv
verilog/dmaRequestOut.sv
verilog/rxDmaCtrl.sv
verification/rxDmaTb.sv

// File: Bender.yml
package:
  name: rx_dma_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rxDmaPkg.sv
      - verilog/recordFifo.sv
      - verilog/rxFrameInput.sv
      - verilog/descScheduler.sv
      - verilog/dmaRequestOut.sv
      - verilog/rxDmaCtrl.sv
  - target: test
    include_dirs:
      - verilog
      - verification
    files:
      - verification/rxDmaTb.sv
